// ==== source/rv_exec_params.svh ====
// width and count macros for the rv32 execute slice
// include wherever a data width or register address is sized
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// data path width, fixed by rv32
`define RV_XLEN 32

// integer register file size
`define RV_NUM_REGS 32
`define RV_REG_AW 5

`endif

// ==== source/rv_isa_pkg.sv ====
// rv32 instruction encoding for the OP and OP-IMM groups
// import where an instruction word is built or decoded
`include "rv_exec_params.svh"

package rv_isa_pkg;

  // major opcodes handled by the slice
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } rv_opcode_e;

  // funct3 field, shared by register and immediate forms
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } rv_funct3_e;

  // register-register layout, msb first
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_r_view_s;

  // register-immediate layout
  typedef struct packed {
    logic [11:0]           imm12;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_i_view_s;

  // one word, two readings
  typedef union packed {
    rv_r_view_s r;
    rv_i_view_s i;
  } rv_instr_u;

endpackage

// ==== source/rv_exec_pkg.sv ====
// execute-side operation codes for the alu, shifter and result mux
// import in the controller and in the units it drives

package rv_exec_pkg;

  // arithmetic and logic unit operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // shifter operations
  typedef enum logic [1:0] {
    SH_SLL,
    SH_SRL,
    SH_SRA
  } shift_op_e;

  // which unit feeds write-back and the host result
  typedef enum logic {
    RES_ALU,
    RES_SHIFT
  } res_src_e;

endpackage

// ==== source/rv_regfile.sv ====
// integer register file, two async read ports and one write port
// x0 reads as zero and drops writes
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_regfile (
  input  logic                  clk,
  // read side
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data,
  // write side
  input  logic                  wr_en,
  input  logic [`RV_REG_AW-1:0] wr_addr,
  input  logic [`RV_XLEN-1:0]   wr_data
);

  // ********************************************************
  // storage
  // ********************************************************

  // entry 0 exists but is never written
  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // write at the edge, x0 filtered here
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // ********************************************************
  // read ports
  // ********************************************************

  // port a, forced zero for x0
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  // port b, same rule
  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

// ==== source/rv_alu.sv ====
// combinational add, subtract, logic and set-less-than unit
// op selected by the issue controller, result in the same cycle
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_alu
  import rv_exec_pkg::*;
(
  input  logic [`RV_XLEN-1:0] op_a,
  input  logic [`RV_XLEN-1:0] op_b,
  input  alu_op_e             alu_op,
  output logic [`RV_XLEN-1:0] alu_result
);

  // shared subtractor, feeds SUB
  logic [`RV_XLEN-1:0] diff;
  // compare flags
  logic                lt_signed;
  logic                lt_unsigned;

  assign diff = op_a - op_b;

  // signed view for SLT
  assign lt_signed = $signed(op_a) < $signed(op_b);
  // plain magnitude for SLTU
  assign lt_unsigned = op_a < op_b;

  // ********************************************************
  // result select
  // ********************************************************

  always_comb begin
    case (alu_op)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = diff;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR: alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      // compares give 0 or 1 in the low bit
      ALU_SLT: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      default: alu_result = '0;
    endcase
  end

endmodule

// ==== source/rv_shifter.sv ====
// combinational barrel shifter for SLL, SRL and SRA
// sits beside the alu, shift amount already reduced to 5 bits
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_shifter
  import rv_exec_pkg::*;
(
  input  logic [`RV_XLEN-1:0] shift_val,
  input  logic [4:0]          shamt,
  input  shift_op_e           shift_op,
  output logic [`RV_XLEN-1:0] shift_result
);

  // arithmetic right shift, sign copied into the vacated bits
  logic [`RV_XLEN-1:0] sra_val;

  assign sra_val = $signed(shift_val) >>> shamt;

  always_comb begin
    case (shift_op)
      // zeros in from the right
      SH_SLL: shift_result = shift_val << shamt;
      // zeros in from the left
      SH_SRL: shift_result = shift_val >> shamt;
      SH_SRA: shift_result = sra_val;
      default: shift_result = '0;
    endcase
  end

endmodule

// ==== source/rv_issue_ctrl.sv ====
// decode, operand select, result select and req/ack handshake
// one instruction per four-phase transfer, write-back on the accept edge
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_issue_ctrl
  import rv_isa_pkg::*;
  import rv_exec_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // host side
  input  logic                  req,
  input  rv_instr_u             instr,
  output logic                  ack,
  output logic [`RV_XLEN-1:0]   result,
  output logic                  illegal,
  // register file reads
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic [`RV_XLEN-1:0]   rs1_data,
  input  logic [`RV_XLEN-1:0]   rs2_data,
  // alu and shifter
  output logic [`RV_XLEN-1:0]   op_a,
  output logic [`RV_XLEN-1:0]   op_b,
  output alu_op_e               alu_op,
  input  logic [`RV_XLEN-1:0]   alu_result,
  output logic [`RV_XLEN-1:0]   shift_val,
  output logic [4:0]            shamt,
  output shift_op_e             shift_op,
  input  logic [`RV_XLEN-1:0]   shift_result,
  // write-back
  output logic                  wr_en,
  output logic [`RV_REG_AW-1:0] wr_addr,
  output logic [`RV_XLEN-1:0]   wr_data
);

  typedef enum logic [1:0] {
    IDLE,
    DONE,
    RELEASE
  } state_e;

  state_e              state_q;
  logic                is_op;
  logic                is_imm;
  logic                alt_ok;
  logic                chk_funct7;
  logic                funct7_ok;
  logic                legal;
  res_src_e            res_src;
  logic [`RV_XLEN-1:0] imm_sext;
  logic [`RV_XLEN-1:0] exec_result;

  // ********************************************************
  // decode
  // ********************************************************

  assign is_op  = instr.r.opcode == OPC_OP;
  assign is_imm = instr.i.opcode == OPC_OP_IMM;

  // rs2 field is imm bits on OP-IMM, read anyway and ignored
  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;

  // imm12 sign extended to the data width
  assign imm_sext = {{(`RV_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

  // funct3 picks the op, funct7 bit 5 picks SUB or SRA
  always_comb begin
    alu_op   = ALU_ADD;
    shift_op = SH_SLL;
    res_src  = RES_ALU;
    alt_ok   = 1'b0;
    case (rv_funct3_e'(instr.r.funct3))
      F3_ADD_SUB: begin
        // no SUBI, imm bit 10 is just data there
        alu_op = (is_op && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
        alt_ok = is_op;
      end
      F3_SLL: begin
        res_src  = RES_SHIFT;
        shift_op = SH_SLL;
      end
      F3_SLT: alu_op = ALU_SLT;
      F3_SLTU: alu_op = ALU_SLTU;
      F3_XOR: alu_op = ALU_XOR;
      F3_SRL_SRA: begin
        res_src  = RES_SHIFT;
        shift_op = instr.r.funct7[5] ? SH_SRA : SH_SRL;
        alt_ok   = 1'b1;
      end
      F3_OR: alu_op = ALU_OR;
      F3_AND: alu_op = ALU_AND;
      default: alu_op = ALU_ADD;
    endcase
  end

  // funct7 only constrained on OP and on shift-immediates
  assign chk_funct7 = is_op || (res_src == RES_SHIFT);
  assign funct7_ok  = (instr.r.funct7 == 7'h00) || ((instr.r.funct7 == 7'h20) && alt_ok);
  assign legal      = (is_op || is_imm) && (!chk_funct7 || funct7_ok);

  // ********************************************************
  // operands and result
  // ********************************************************

  assign op_a      = rs1_data;
  assign op_b      = is_imm ? imm_sext : rs2_data;
  assign shift_val = rs1_data;
  // register form uses only the low 5 bits of rs2
  assign shamt     = is_imm ? instr.r.rs2 : rs2_data[4:0];

  assign exec_result = (res_src == RES_SHIFT) ? shift_result : alu_result;

  // write on the accept edge only, x0 dropped by the register file
  assign wr_en   = (state_q == IDLE) && req && legal;
  assign wr_addr = instr.r.rd;
  assign wr_data = exec_result;

  // ********************************************************
  // handshake fsm
  // ********************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      ack     <= 1'b0;
      result  <= '0;
      illegal <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req) begin
            // capture and answer
            result  <= legal ? exec_result : '0;
            illegal <= !legal;
            ack     <= 1'b1;
            state_q <= DONE;
          end
        end
        // hold ack and result while req stays high
        DONE: begin
          if (!req) begin
            ack     <= 1'b0;
            state_q <= RELEASE;
          end
        end
        // one dead cycle before a new req is sampled
        RELEASE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== source/rv_exec_unit.sv ====
// top of the integer execute slice
// host side is a four-phase req/ack port carrying one instruction word
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_exec_unit
  import rv_isa_pkg::*;
  import rv_exec_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req,
  input  rv_instr_u           instr,
  output logic                ack,
  output logic [`RV_XLEN-1:0] result,
  output logic                illegal
);

  // register file ports
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic                  wr_en;
  logic [`RV_REG_AW-1:0] wr_addr;
  logic [`RV_XLEN-1:0]   wr_data;
  // execute units
  logic [`RV_XLEN-1:0]   op_a;
  logic [`RV_XLEN-1:0]   op_b;
  alu_op_e               alu_op;
  logic [`RV_XLEN-1:0]   alu_result;
  logic [`RV_XLEN-1:0]   shift_val;
  logic [4:0]            shamt;
  shift_op_e             shift_op;
  logic [`RV_XLEN-1:0]   shift_result;

  // ********************************************************
  // control
  // ********************************************************

  rv_issue_ctrl rv_issue_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .instr        (instr),
    .ack          (ack),
    .result       (result),
    .illegal      (illegal),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .op_a         (op_a),
    .op_b         (op_b),
    .alu_op       (alu_op),
    .alu_result   (alu_result),
    .shift_val    (shift_val),
    .shamt        (shamt),
    .shift_op     (shift_op),
    .shift_result (shift_result),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  // ********************************************************
  // datapath
  // ********************************************************

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  // alu and shifter run side by side, controller picks one
  rv_alu rv_alu_inst (
    .op_a       (op_a),
    .op_b       (op_b),
    .alu_op     (alu_op),
    .alu_result (alu_result)
  );

  rv_shifter rv_shifter_inst (
    .shift_val    (shift_val),
    .shamt        (shamt),
    .shift_op     (shift_op),
    .shift_result (shift_result)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
// clock and reset source for the execute slice testbench
// 8 ns clock, rst_n held low for the first 4 rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // low before the first edge so reset is seen from cycle 0
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

  // half period 4 ns
  always #4 clk = ~clk;

endmodule

// ==== bench/rv_exec_sva.sv ====
// concurrent checks on the req/ack handshake and on x0 reads
// bound into every rv_issue_ctrl instance by the bind at the end
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module rv_exec_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req,
  input logic                  ack,
  input logic [`RV_XLEN-1:0]   result,
  input logic                  wr_en,
  input logic [`RV_REG_AW-1:0] rs1_addr,
  input logic [`RV_XLEN-1:0]   rs1_data
);

  // ********************************************************
  // handshake
  // ********************************************************

  // second reset edge onward, ack already cleared
  ack_low_in_reset: assert property (@(posedge clk) !rst_n && !$past(rst_n) |-> !ack)
    else $error("ack high while reset is asserted");

  // ack drops only once req was seen low
  ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  // ack rises only on an accepted req
  ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a req");

  // back-pressure, answer frozen
  result_held: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(result))
    else $error("result changed while ack was held");

  // no second write while the host holds req
  one_write: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !ack)
    else $error("register write while ack is high");

  // ********************************************************
  // x0
  // ********************************************************

  x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |=> (rs1_addr != '0) || (rs1_data == '0))
    else $error("x0 read back nonzero after a write");

endmodule

bind rv_issue_ctrl rv_exec_sva rv_exec_sva_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .req      (req),
  .ack      (ack),
  .result   (result),
  .wr_en    (wr_en),
  .rs1_addr (rs1_addr),
  .rs1_data (rs1_data)
);

// ==== bench/tb_rv_exec_unit.sv ====
// testbench for the execute slice, drives four-phase transfers
// and checks each answer against a shadow register model
`timescale 1ns/1ps
`include "rv_exec_params.svh"

module tb_rv_exec_unit
  import rv_isa_pkg::*;
();

  // regreg, imm, shift, x0, illegal, back-pressure
  localparam int NUM_XFERS   = 102 + 12 + 31 + 2 + 4 + 12;
  localparam int CYCLE_LIMIT = NUM_XFERS * 8 + 100;

  logic                clk;
  logic                rst_n;
  logic                req;
  rv_instr_u           instr;
  logic                ack;
  logic [`RV_XLEN-1:0] result;
  logic                illegal;

  logic [`RV_XLEN-1:0] shadow [`RV_NUM_REGS];
  string               cur_test;
  int                  test_errors;
  int                  test_xfers;
  int                  tests_passed;
  int                  tests_failed;
  int                  cycles;

  tb_clk_gen tb_clk_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_exec_unit rv_exec_unit_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .instr   (instr),
    .ack     (ack),
    .result  (result),
    .illegal (illegal)
  );

  // ********************************************************
  // instruction builders
  // ********************************************************

  function automatic rv_instr_u make_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [4:0] rs2);
    rv_instr_u w;
    w          = '0;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic rv_instr_u make_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                       logic [11:0] imm);
    rv_instr_u w;
    w          = '0;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = OPC_OP_IMM;
    return w;
  endfunction

  // any of the seven register-register alu ops, random sources
  function automatic rv_instr_u random_rr(logic [4:0] rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = 7'h00;
    case ($urandom_range(6, 0))
      0: f3 = F3_ADD_SUB;
      1: begin
        f3 = F3_ADD_SUB;
        f7 = 7'h20;
      end
      2: f3 = F3_AND;
      3: f3 = F3_OR;
      4: f3 = F3_XOR;
      5: f3 = F3_SLT;
      default: f3 = F3_SLTU;
    endcase
    return make_r(f7, f3, rd, 5'($urandom), 5'($urandom));
  endfunction

  // ********************************************************
  // reference model, straight from the rv32 OP / OP-IMM rules
  // ********************************************************

  function automatic void predict(input rv_instr_u w, output logic [`RV_XLEN-1:0] res,
                                  output logic ill);
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [4:0]          sh;
    logic                is_reg;
    logic                bad_f7;
    is_reg = (w.r.opcode == OPC_OP);
    a      = shadow[w.r.rs1];
    b      = is_reg ? shadow[w.r.rs2] : {{(`RV_XLEN-12){w.i.imm12[11]}}, w.i.imm12};
    // register shifts take only the low 5 bits of rs2
    sh     = is_reg ? b[4:0] : w.r.rs2;
    bad_f7 = is_reg && (w.r.funct7 != 7'h00);
    res    = '0;
    ill    = 1'b0;
    if (!is_reg && (w.i.opcode != OPC_OP_IMM)) begin
      ill = 1'b1;
    end else begin
      case (w.r.funct3)
        3'b000: begin
          if (is_reg && (w.r.funct7 == 7'h20)) res = a - b;
          else if (bad_f7) ill = 1'b1;
          else res = a + b;
        end
        // SLL and SLLI both need funct7 zero
        3'b001: begin
          if (w.r.funct7 != 7'h00) ill = 1'b1;
          else res = a << sh;
        end
        3'b101: begin
          if (w.r.funct7 == 7'h00) res = a >> sh;
          else if (w.r.funct7 == 7'h20) res = $signed(a) >>> sh;
          else ill = 1'b1;
        end
        3'b010: res = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        3'b011: res = {{(`RV_XLEN-1){1'b0}}, a < b};
        3'b100: res = a ^ b;
        3'b110: res = a | b;
        default: res = a & b;
      endcase
      // alu ops without an alternate form
      if (bad_f7 && (w.r.funct3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111})) begin
        ill = 1'b1;
      end
    end
    if (ill) res = '0;
  endfunction

  // ********************************************************
  // host side
  // ********************************************************

  // one four-phase transfer, req held for hold extra cycles after ack
  task automatic transfer(input rv_instr_u word, input int hold,
                          output logic [`RV_XLEN-1:0] res, output logic ill);
    @(posedge clk);
    instr <= word;
    req   <= 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    res = result;
    ill = illegal;
    repeat (hold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
  endtask

  task automatic run_instr(input rv_instr_u w, input int hold);
    logic [`RV_XLEN-1:0] exp_res;
    logic [`RV_XLEN-1:0] act_res;
    logic                exp_ill;
    logic                act_ill;
    predict(w, exp_res, exp_ill);
    transfer(w, hold, act_res, act_ill);
    test_xfers++;
    assert (act_ill === exp_ill) else begin
      $display("MISMATCH %s illegal: expected %0b, actual %0b", cur_test, exp_ill, act_ill);
      test_errors++;
    end
    assert (act_res === exp_res) else begin
      $display("MISMATCH %s result: expected %08h, actual %08h", cur_test, exp_res, act_res);
      test_errors++;
    end
    // shadow write, x0 never changes
    if (!exp_ill && (w.r.rd != '0)) shadow[w.r.rd] = exp_res;
  endtask

  // read through ADD x0, xr, x0 so nothing is written
  task automatic read_back(input logic [4:0] r);
    run_instr(make_r(7'h00, F3_ADD_SUB, 5'd0, r, 5'd0), 0);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    test_xfers  = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s ok, %0d transfers", cur_test, test_xfers);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d mismatches", cur_test, test_errors);
    end
  endtask

  // ********************************************************
  // watchdog
  // ********************************************************

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ********************************************************
  // tests
  // ********************************************************

  initial begin
    rv_instr_u w;
    logic [4:0] rd;
    logic [4:0] amt;
    logic [2:0] imm_ops [6];
    req          = 1'b0;
    instr        = '0;
    cycles       = 0;
    tests_passed = 0;
    tests_failed = 0;
    imm_ops      = '{F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT, F3_SLTU};
    for (int r = 0; r < `RV_NUM_REGS; r++) shadow[r] = '0;
    void'($urandom(32'hf981));
    // rst_n may still be unknown at time zero
    while (rst_n !== 1'b1) @(posedge clk);

    // load x1..x31, random OP mix, then read everything back
    start_test("regreg");
    for (int r = 1; r < `RV_NUM_REGS; r++) begin
      run_instr(make_i(F3_ADD_SUB, 5'(r), 5'd0, 12'($urandom)), 0);
    end
    for (int n = 0; n < 40; n++) begin
      run_instr(random_rr(5'($urandom_range(31, 1))), 0);
    end
    for (int r = 1; r < `RV_NUM_REGS; r++) read_back(5'(r));
    finish_test();

    // each immediate op once negative, once positive
    start_test("imm");
    for (int k = 0; k < 6; k++) begin
      for (int s = 0; s < 2; s++) begin
        w = make_i(imm_ops[k], 5'($urandom_range(31, 1)), 5'($urandom_range(31, 1)),
                   {s == 0, 11'($urandom)});
        run_instr(w, 0);
      end
    end
    finish_test();

    // x20 gets a value with the sign bit set, x21 holds the amount
    start_test("shift");
    run_instr(make_i(F3_ADD_SUB, 5'd20, 5'd0, {1'b1, 11'($urandom)}), 0);
    run_instr(make_i(F3_SLL, 5'd20, 5'd20, {7'h00, 5'd12}), 0);
    run_instr(make_i(F3_OR, 5'd20, 5'd20, {1'b0, 11'($urandom)}), 0);
    for (int k = 0; k < 4; k++) begin
      amt = (k == 0) ? 5'd0 : (k == 1) ? 5'd31 : 5'($urandom);
      // junk above bit 4 of rs2 must be ignored
      run_instr(make_i(F3_ADD_SUB, 5'd21, 5'd0, {7'($urandom), amt}), 0);
      rd = 5'($urandom_range(31, 22));
      run_instr(make_r(7'h00, F3_SLL, rd, 5'd20, 5'd21), 0);
      run_instr(make_r(7'h00, F3_SRL_SRA, rd, 5'd20, 5'd21), 0);
      run_instr(make_r(7'h20, F3_SRL_SRA, rd, 5'd20, 5'd21), 0);
      run_instr(make_i(F3_SLL, rd, 5'd20, {7'h00, amt}), 0);
      run_instr(make_i(F3_SRL_SRA, rd, 5'd20, {7'h00, amt}), 0);
      run_instr(make_i(F3_SRL_SRA, rd, 5'd20, {7'h20, amt}), 0);
    end
    finish_test();

    // result comes back but the write is dropped
    start_test("x0");
    run_instr(make_i(F3_ADD_SUB, 5'd0, 5'd0, 12'd5), 0);
    run_instr(make_r(7'h00, F3_ADD_SUB, 5'd2, 5'd0, 5'd0), 0);
    finish_test();

    // LOAD opcode, then AND with the SUB/SRA funct7
    start_test("illegal");
    w = make_i(3'b010, 5'd3, 5'd1, 12'h004);
    w.i.opcode = 7'b0000011;
    run_instr(w, 0);
    read_back(5'd3);
    run_instr(make_r(7'h20, F3_AND, 5'd4, 5'd1, 5'd2), 0);
    read_back(5'd4);
    finish_test();

    // host keeps req up after ack, only one write allowed
    start_test("backpress");
    for (int n = 0; n < 6; n++) begin
      rd = 5'($urandom_range(31, 1));
      if (n % 2 == 0) w = random_rr(rd);
      else w = make_i(F3_XOR, rd, 5'($urandom), 12'($urandom));
      run_instr(w, int'($urandom_range(10, 1)));
      read_back(rd);
    end
    finish_test();

    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/rv_isa_pkg.sv
source/rv_exec_pkg.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_shifter.sv
source/rv_issue_ctrl.sv
source/rv_exec_unit.sv
bench/tb_clk_gen.sv
bench/rv_exec_sva.sv
bench/tb_rv_exec_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the execute slice regression with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_rv_exec_unit -o sim_rv_exec
./obj_dir/sim_rv_exec | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "simulation reported failing checks"
  exit 1
fi
echo "simulation finished without failing checks"
